//--- list.f
hw/tile_ctrl_pkg.sv
hw/flow_throttle.sv
hw/step_sequencer.sv
hw/edge_padder.sv
hw/tile_ctrl_top.sv
test/tile_ctrl_properties.sv
test/tile_ctrl_checker.sv
test/tile_ctrl_tb.sv

//--- Makefile
# Verilator build and run for the tile controller testbench

SIM = obj_dir/sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal -f list.f --top-module tile_ctrl_tb -o sim

run: compile
	./$(SIM) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/tile_ctrl_tb.sv
/* Testbench for the tile controller. Runs a table of jobs with random valids
   and output back-pressure; tile_ctrl_checker compares the DUT responses. */

module tile_ctrl_tb;
  import tile_ctrl_pkg::*;

  localparam int unsigned TileM     = 8;
  localparam int unsigned Lanes     = 4;
  localparam int unsigned FifoDepth = 8;
  localparam int unsigned DimW      = 10;
  localparam int unsigned BiasW     = 8;
  localparam int unsigned NumJobs   = 6;

  typedef struct {
    layer_e layer;
    int     seq;
    int     embed;
    int     proj;
    int     ff;
    int     stall_pct; // chance of oup_ready low
  } job_t;

  logic                        clk_i = 1'b0;
  logic                        rst_ni;
  logic                        start_i;
  layer_e                      layer_i;
  logic [DimW-1:0]             seq_length_i;
  logic [DimW-1:0]             embed_size_i;
  logic [DimW-1:0]             proj_space_i;
  logic [DimW-1:0]             ff_size_i;
  logic                        inp_valid_i;
  logic                        weight_valid_i;
  logic                        bias_valid_i;
  logic [Lanes-1:0][BiasW-1:0] bias_i;
  logic                        oup_valid_i;
  logic                        oup_ready_i;
  logic                        inp_ready_o;
  logic                        weight_ready_o;
  logic                        bias_ready_o;
  logic                        calc_en_o;
  step_e                       step_o;
  logic [DimW-1:0]             tile_x_o;
  logic [DimW-1:0]             tile_y_o;
  logic [DimW-1:0]             inner_tile_o;
  logic                        first_inner_tile_o;
  logic                        last_inner_tile_o;
  logic [Lanes-1:0][BiasW-1:0] bias_pad_o;
  logic [Lanes-1:0]            requant_add_o;

  job_t jobs[NumJobs];
  int   pending_q[$]; // output beats not yet taken
  int   out_beats;
  int   stall_pct;
  int   limit_cycles;

  tile_ctrl_top #(
    .TileM(TileM), .Lanes(Lanes), .FifoDepth(FifoDepth), .DimW(DimW), .BiasW(BiasW)
  ) u_dut (.*);

  tile_ctrl_checker #(
    .TileM(TileM), .Lanes(Lanes), .FifoDepth(FifoDepth), .DimW(DimW), .BiasW(BiasW)
  ) u_checker (
    .clk_i(clk_i), .rst_ni(rst_ni), .start_i(start_i), .layer_i(layer_i),
    .seq_length_i(seq_length_i), .embed_size_i(embed_size_i),
    .proj_space_i(proj_space_i), .ff_size_i(ff_size_i),
    .inp_valid_i(inp_valid_i), .weight_valid_i(weight_valid_i),
    .bias_valid_i(bias_valid_i), .bias_i(bias_i),
    .oup_valid_i(oup_valid_i), .oup_ready_i(oup_ready_i),
    .inp_ready_i(inp_ready_o), .weight_ready_i(weight_ready_o),
    .bias_ready_i(bias_ready_o), .calc_en_i(calc_en_o), .step_i(step_o),
    .tile_x_i(tile_x_o), .tile_y_i(tile_y_o), .inner_tile_i(inner_tile_o),
    .first_inner_i(first_inner_tile_o), .last_inner_i(last_inner_tile_o),
    .bias_pad_i(bias_pad_o), .requant_add_i(requant_add_o)
  );

  always #4 clk_i = ~clk_i;

  function automatic int ceil_tiles(input int size);
    return (size + TileM - 1) / TileM;
  endfunction

  // accepted beats for a whole job, over all of its steps
  function automatic int job_beats(input int j);
    int per_tile;
    per_tile = TileM * TileM / Lanes;
    if (jobs[j].layer == LINEAR) begin
      return ceil_tiles(jobs[j].seq) * ceil_tiles(jobs[j].proj)
           * ceil_tiles(jobs[j].embed) * per_tile;
    end
    return 2 * ceil_tiles(jobs[j].seq) * ceil_tiles(jobs[j].ff)
         * ceil_tiles(jobs[j].embed) * per_tile;
  endfunction

  // output side: pop on handshake, push on each output-producing beat
  always @(negedge clk_i) begin
    if (oup_valid_i && oup_ready_i && pending_q.size() != 0) begin
      void'(pending_q.pop_front());
    end
    if (calc_en_o && last_inner_tile_o) begin
      pending_q.push_back(out_beats);
      out_beats++;
    end
  end

  always @(posedge clk_i) begin
    oup_valid_i <= pending_q.size() != 0;
    oup_ready_i <= $urandom_range(99) >= stall_pct;
  end

  task automatic run_job(input int j);
    logic busy;
    @(posedge clk_i);
    layer_i      <= jobs[j].layer;
    seq_length_i <= DimW'(jobs[j].seq);
    embed_size_i <= DimW'(jobs[j].embed);
    proj_space_i <= DimW'(jobs[j].proj);
    ff_size_i    <= DimW'(jobs[j].ff);
    stall_pct = jobs[j].stall_pct;
    start_i <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    do begin
      inp_valid_i    <= $urandom_range(99) < 85;
      weight_valid_i <= $urandom_range(99) < 85;
      bias_valid_i   <= $urandom_range(99) < 85;
      bias_i         <= $urandom();
      @(negedge clk_i);
      busy = step_o != IDLE;
      @(posedge clk_i);
    end while (busy);
    inp_valid_i    <= 1'b0;
    weight_valid_i <= 1'b0;
    bias_valid_i   <= 1'b0;
    $display("job %0d %s: %0d beats, %0d errors so far",
             j, jobs[j].layer.name(), job_beats(j), u_checker.errors);
  endtask

  initial begin
    void'($urandom(66));
    jobs[0] = '{LINEAR,      16, 16, 16, 8,  0};
    jobs[1] = '{LINEAR,      13, 20, 9,  8,  30};
    jobs[2] = '{FEEDFORWARD, 16, 8,  8,  16, 20};
    jobs[3] = '{FEEDFORWARD, 12, 20, 8,  9,  40};
    jobs[4] = '{LINEAR,      5,  3,  7,  8,  10};
    jobs[5] = '{FEEDFORWARD, 17, 11, 8,  6,  35};
    limit_cycles = 0;
    for (int j = 0; j < NumJobs; j++) begin
      limit_cycles += job_beats(j) * 4 + 100;
    end
    rst_ni         = 1'b0;
    start_i        = 1'b0;
    layer_i        = LINEAR;
    seq_length_i   = '0;
    embed_size_i   = '0;
    proj_space_i   = '0;
    ff_size_i      = '0;
    inp_valid_i    = 1'b0;
    weight_valid_i = 1'b0;
    bias_valid_i   = 1'b0;
    bias_i         = '0;
    oup_valid_i    = 1'b0;
    oup_ready_i    = 1'b0;
    out_beats      = 0;
    stall_pct      = 0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int j = 0; j < NumJobs; j++) begin
      run_job(j);
    end
    repeat (20) @(posedge clk_i); // let the output queue drain
    $display("checks %0d, errors %0d", u_checker.checks, u_checker.errors);
    if (u_checker.errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles + 50) @(posedge clk_i);
    $display("watchdog expired: a job never returned to IDLE");
    $display("Test failed");
    $finish;
  end

endmodule

//--- test/tile_ctrl_checker.sv
/* Watches the controller ports and compares them each cycle with a model
   built from the step tables, handshake and padding rules. */

module tile_ctrl_checker #(
  parameter int unsigned TileM     = 8,
  parameter int unsigned Lanes     = 4,
  parameter int unsigned FifoDepth = 8,
  parameter int unsigned DimW      = 10,
  parameter int unsigned BiasW     = 8
) (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        start_i,
  input tile_ctrl_pkg::layer_e       layer_i,
  input logic [DimW-1:0]             seq_length_i,
  input logic [DimW-1:0]             embed_size_i,
  input logic [DimW-1:0]             proj_space_i,
  input logic [DimW-1:0]             ff_size_i,
  input logic                        inp_valid_i,
  input logic                        weight_valid_i,
  input logic                        bias_valid_i,
  input logic [Lanes-1:0][BiasW-1:0] bias_i,
  input logic                        oup_valid_i,
  input logic                        oup_ready_i,
  input logic                        inp_ready_i,
  input logic                        weight_ready_i,
  input logic                        bias_ready_i,
  input logic                        calc_en_i,
  input tile_ctrl_pkg::step_e        step_i,
  input logic [DimW-1:0]             tile_x_i,
  input logic [DimW-1:0]             tile_y_i,
  input logic [DimW-1:0]             inner_tile_i,
  input logic                        first_inner_i,
  input logic                        last_inner_i,
  input logic [Lanes-1:0][BiasW-1:0] bias_pad_i,
  input logic [Lanes-1:0]            requant_add_i
);
  import tile_ctrl_pkg::*;

  localparam int BeatsPerTile = TileM * TileM / Lanes;

  int    errors = 0;
  int    checks = 0;
  step_e m_step = IDLE;
  int    m_beat = 0;
  int    m_tx = 0;
  int    m_ty = 0;
  int    m_inner = 0;
  int    m_outst = 0;   // outstanding output beats
  int    step_beats = 0; // calc_en beats seen from the DUT in this step
  logic [Lanes-1:0][BiasW-1:0] exp_pad = '0;
  logic [Lanes-1:0]            exp_mask = '0;

  function automatic int tiles(input int size);
    return (size + TileM - 1) / TileM;
  endfunction

  task automatic compare(input string name, input longint exp, input longint act);
    checks++;
    if (exp != act) begin
      errors++;
      $display("Fail at %0t: %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  always @(negedge clk_i) begin : watch
    int   xt, it, d1, d2, row, col;
    logic act, accept, last;
    xt = 0;
    it = 0;
    d1 = int'(seq_length_i);
    d2 = 0;
    case (m_step)
      MATMUL: begin
        xt = tiles(proj_space_i);
        it = tiles(embed_size_i);
        d2 = proj_space_i;
      end
      F1: begin
        xt = tiles(ff_size_i);
        it = tiles(embed_size_i);
        d2 = ff_size_i;
      end
      F2: begin
        xt = tiles(embed_size_i);
        it = tiles(ff_size_i);
        d2 = embed_size_i;
      end
      default: ;
    endcase
    act    = (m_step != IDLE) && (m_outst < FifoDepth);
    accept = act && inp_valid_i && weight_valid_i && bias_valid_i;
    last   = m_inner == it - 1;
    compare("step_o", longint'(m_step), longint'(step_i));
    compare("inp_ready_o", act && weight_valid_i, inp_ready_i);
    compare("weight_ready_o", act && inp_valid_i, weight_ready_i);
    compare("bias_ready_o", act && weight_valid_i, bias_ready_i);
    compare("calc_en_o", accept, calc_en_i);
    compare("bias_pad_o", exp_pad, bias_pad_i);
    compare("requant_add_o", exp_mask, requant_add_i);
    if (!rst_ni) begin
      m_step = IDLE;
      m_beat = 0;
      m_tx = 0;
      m_ty = 0;
      m_inner = 0;
      m_outst = 0;
      step_beats = 0;
      exp_pad = '0;
      exp_mask = '0;
    end else begin
      m_outst += ((accept && last) ? 1 : 0) - ((oup_valid_i && oup_ready_i) ? 1 : 0);
      if (calc_en_i) begin
        step_beats++;
      end
      if (accept) begin
        compare("tile_x_o", m_tx, tile_x_i);
        compare("tile_y_o", m_ty, tile_y_i);
        compare("inner_tile_o", m_inner, inner_tile_i);
        compare("first_inner_tile_o", m_inner == 0, first_inner_i);
        compare("last_inner_tile_o", last, last_inner_i);
        row = m_ty * TileM + m_beat % TileM;
        for (int k = 0; k < Lanes; k++) begin
          col = m_tx * TileM + (m_beat / TileM) * Lanes + k;
          exp_mask[k] = (row < d1) && (col < d2);
          exp_pad[k]  = exp_mask[k] ? bias_i[k] : '0;
        end
        if (m_beat == BeatsPerTile - 1) begin
          m_beat = 0;
          if (last) begin
            m_inner = 0;
            if (m_tx == xt - 1) begin
              m_tx = 0;
              if (m_ty == tiles(seq_length_i) - 1) begin // step done
                m_ty = 0;
                compare("beats per step", tiles(seq_length_i) * xt * it * BeatsPerTile,
                        step_beats);
                step_beats = 0;
                m_step = (m_step == F1) ? F2 : IDLE;
              end else m_ty++;
            end else m_tx++;
          end else m_inner++;
        end else m_beat++;
      end else if (m_step == IDLE && start_i) begin
        m_step = (layer_i == LINEAR) ? MATMUL : F1;
        step_beats = 0;
      end
    end
  end

endmodule

//--- test/tile_ctrl_properties.sv
/* Concurrent assertions on reset and handshake behavior, bound into
   tile_ctrl_top. */

module tile_ctrl_properties (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 inp_valid_i,
  input logic                 weight_valid_i,
  input logic                 bias_valid_i,
  input logic                 inp_ready_i,
  input logic                 weight_ready_i,
  input logic                 bias_ready_i,
  input logic                 calc_en_i,
  input tile_ctrl_pkg::step_e step_i
);
  import tile_ctrl_pkg::*;

  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !calc_en_i && !inp_ready_i && !weight_ready_i && !bias_ready_i
                && step_i == IDLE)
    else $error("handshake active or step not IDLE during reset");

  idle_quiet: assert property (@(posedge clk_i)
    step_i == IDLE |-> !calc_en_i && !inp_ready_i && !weight_ready_i && !bias_ready_i)
    else $error("readies or calc_en high in IDLE");

  // accept needs all three valids and readies
  accept_needs_all: assert property (@(posedge clk_i) disable iff (!rst_ni)
    calc_en_i |-> inp_valid_i && weight_valid_i && bias_valid_i
                  && inp_ready_i && weight_ready_i && bias_ready_i)
    else $error("calc_en high without full handshake");

  accept_when_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    inp_valid_i && weight_valid_i && bias_valid_i && inp_ready_i |-> calc_en_i)
    else $error("full handshake without calc_en");

endmodule

bind tile_ctrl_top tile_ctrl_properties u_props (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .inp_valid_i   (inp_valid_i),
  .weight_valid_i(weight_valid_i),
  .bias_valid_i  (bias_valid_i),
  .inp_ready_i   (inp_ready_o),
  .weight_ready_i(weight_ready_o),
  .bias_ready_i  (bias_ready_o),
  .calc_en_i     (calc_en_o),
  .step_i        (step_o)
);

//--- hw/tile_ctrl_top.sv
/* Top of the tile-sequencing controller. Host gives layer, sizes and start;
   sequencer, throttle and padder are wired here. */

module tile_ctrl_top #(
  parameter int unsigned TileM     = tile_ctrl_pkg::TileM,
  parameter int unsigned Lanes     = tile_ctrl_pkg::Lanes,
  parameter int unsigned FifoDepth = tile_ctrl_pkg::FifoDepth,
  parameter int unsigned DimW      = tile_ctrl_pkg::DimW,
  parameter int unsigned BiasW     = tile_ctrl_pkg::BiasW
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            start_i,
  input  tile_ctrl_pkg::layer_e           layer_i,
  input  logic [DimW-1:0]                 seq_length_i,
  input  logic [DimW-1:0]                 embed_size_i,
  input  logic [DimW-1:0]                 proj_space_i,
  input  logic [DimW-1:0]                 ff_size_i,
  input  logic                            inp_valid_i,
  input  logic                            weight_valid_i,
  input  logic                            bias_valid_i,
  input  logic [Lanes-1:0][BiasW-1:0]     bias_i,
  input  logic                            oup_valid_i,
  input  logic                            oup_ready_i,
  output logic                            inp_ready_o,
  output logic                            weight_ready_o,
  output logic                            bias_ready_o,
  output logic                            calc_en_o,
  output tile_ctrl_pkg::step_e            step_o,
  output logic [DimW-1:0]                 tile_x_o,
  output logic [DimW-1:0]                 tile_y_o,
  output logic [DimW-1:0]                 inner_tile_o,
  output logic                            first_inner_tile_o,
  output logic                            last_inner_tile_o,
  output logic [Lanes-1:0][BiasW-1:0]     bias_pad_o,
  output logic [Lanes-1:0]                requant_add_o
);

  logic [$clog2(TileM*TileM/Lanes)-1:0] beat;
  logic [DimW-1:0]                      first_dim;
  logic [DimW-1:0]                      second_dim;

  step_sequencer #(
    .TileM(TileM),
    .Lanes(Lanes),
    .DimW (DimW)
  ) u_step_sequencer (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .start_i           (start_i),
    .layer_i           (layer_i),
    .seq_length_i      (seq_length_i),
    .embed_size_i      (embed_size_i),
    .proj_space_i      (proj_space_i),
    .ff_size_i         (ff_size_i),
    .accept_i          (calc_en_o),
    .step_o            (step_o),
    .beat_o            (beat),
    .tile_x_o          (tile_x_o),
    .tile_y_o          (tile_y_o),
    .inner_tile_o      (inner_tile_o),
    .first_inner_tile_o(first_inner_tile_o),
    .last_inner_tile_o (last_inner_tile_o),
    .first_dim_o       (first_dim),
    .second_dim_o      (second_dim)
  );

  flow_throttle #(
    .FifoDepth(FifoDepth)
  ) u_flow_throttle (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .step_i           (step_o),
    .last_inner_tile_i(last_inner_tile_o),
    .inp_valid_i      (inp_valid_i),
    .weight_valid_i   (weight_valid_i),
    .bias_valid_i     (bias_valid_i),
    .oup_valid_i      (oup_valid_i),
    .oup_ready_i      (oup_ready_i),
    .inp_ready_o      (inp_ready_o),
    .weight_ready_o   (weight_ready_o),
    .bias_ready_o     (bias_ready_o),
    .accept_o         (calc_en_o)
  );

  edge_padder #(
    .TileM(TileM),
    .Lanes(Lanes),
    .DimW (DimW),
    .BiasW(BiasW)
  ) u_edge_padder (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .accept_i     (calc_en_o),
    .beat_i       (beat),
    .tile_x_i     (tile_x_o),
    .tile_y_i     (tile_y_o),
    .first_dim_i  (first_dim),
    .second_dim_i (second_dim),
    .bias_i       (bias_i),
    .bias_pad_o   (bias_pad_o),
    .requant_add_o(requant_add_o)
  );

endmodule

//--- hw/edge_padder.sv
/* Edge padding for the bias lanes and the requant-add mask.
   Lanes past the real matrix are zeroed; results register on each accepted beat. */

module edge_padder #(
  parameter int unsigned TileM = tile_ctrl_pkg::TileM,
  parameter int unsigned Lanes = tile_ctrl_pkg::Lanes,
  parameter int unsigned DimW  = tile_ctrl_pkg::DimW,
  parameter int unsigned BiasW = tile_ctrl_pkg::BiasW
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 accept_i,
  input  logic [$clog2(TileM*TileM/Lanes)-1:0] beat_i,
  input  logic [DimW-1:0]                      tile_x_i,
  input  logic [DimW-1:0]                      tile_y_i,
  input  logic [DimW-1:0]                      first_dim_i,
  input  logic [DimW-1:0]                      second_dim_i,
  input  logic [Lanes-1:0][BiasW-1:0]          bias_i,
  output logic [Lanes-1:0][BiasW-1:0]          bias_pad_o,
  output logic [Lanes-1:0]                     requant_add_o
);

  localparam int unsigned ShiftM    = $clog2(TileM);
  localparam int unsigned LaneShift = $clog2(Lanes);
  localparam int unsigned CoordW    = DimW + 1; // room for the ragged last tile

  logic [CoordW-1:0]             row;
  logic [CoordW-1:0]             col_base;
  logic [Lanes-1:0]              keep;
  logic [Lanes-1:0][BiasW-1:0]   bias_pad_d, bias_pad_q;
  logic [Lanes-1:0]              requant_q;

  // beat mod M picks the row, beat div M the lane group
  assign row      = (CoordW'(tile_y_i) << ShiftM) + CoordW'(beat_i[ShiftM-1:0]);
  assign col_base = (CoordW'(tile_x_i) << ShiftM)
                  + (CoordW'(beat_i >> ShiftM) << LaneShift);

  always_comb begin
    for (int k = 0; k < Lanes; k++) begin
      keep[k] = (row < CoordW'(first_dim_i))
             && ((col_base + CoordW'(k)) < CoordW'(second_dim_i));
      bias_pad_d[k] = keep[k] ? bias_i[k] : '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bias_pad_q <= '0;
      requant_q  <= '0;
    end else if (accept_i) begin // hold under back-pressure
      bias_pad_q <= bias_pad_d;
      requant_q  <= keep;
    end
  end

  assign bias_pad_o    = bias_pad_q;
  assign requant_add_o = requant_q;

endmodule

//--- hw/step_sequencer.sv
/* Step FSM with beat, inner-tile and output-tile counters.
   Advances one beat per accept and reports the outer sizes of the current step. */

module step_sequencer #(
  parameter int unsigned TileM = tile_ctrl_pkg::TileM,
  parameter int unsigned Lanes = tile_ctrl_pkg::Lanes,
  parameter int unsigned DimW  = tile_ctrl_pkg::DimW
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 start_i,
  input  tile_ctrl_pkg::layer_e                layer_i,
  input  logic [DimW-1:0]                      seq_length_i,
  input  logic [DimW-1:0]                      embed_size_i,
  input  logic [DimW-1:0]                      proj_space_i,
  input  logic [DimW-1:0]                      ff_size_i,
  input  logic                                 accept_i,
  output tile_ctrl_pkg::step_e                 step_o,
  output logic [$clog2(TileM*TileM/Lanes)-1:0] beat_o,
  output logic [DimW-1:0]                      tile_x_o,
  output logic [DimW-1:0]                      tile_y_o,
  output logic [DimW-1:0]                      inner_tile_o,
  output logic                                 first_inner_tile_o,
  output logic                                 last_inner_tile_o,
  output logic [DimW-1:0]                      first_dim_o,
  output logic [DimW-1:0]                      second_dim_o
);
  import tile_ctrl_pkg::*;

  localparam int unsigned BeatsPerTile = TileM * TileM / Lanes;
  localparam int unsigned BeatW        = $clog2(BeatsPerTile);
  localparam int unsigned ShiftM       = $clog2(TileM);
  localparam int unsigned PadW         = DimW + 1;

  step_e            step_d, step_q;
  logic [BeatW-1:0] beat_d, beat_q;
  logic [DimW-1:0]  tile_x_d, tile_x_q;
  logic [DimW-1:0]  tile_y_d, tile_y_q;
  logic [DimW-1:0]  inner_tile_d, inner_tile_q;

  logic [DimW-1:0]  seq_tiles, embed_tiles, proj_tiles, ff_tiles;
  logic [DimW-1:0]  x_tiles, inner_tiles;
  logic             last_beat, last_inner, last_x, last_y;

  // size / M, rounded up
  function automatic logic [DimW-1:0] num_tiles(input logic [DimW-1:0] size);
    logic [PadW-1:0] padded;
    padded = {1'b0, size} + PadW'(TileM - 1);
    return DimW'(padded >> ShiftM);
  endfunction

  assign seq_tiles   = num_tiles(seq_length_i);
  assign embed_tiles = num_tiles(embed_size_i);
  assign proj_tiles  = num_tiles(proj_space_i);
  assign ff_tiles    = num_tiles(ff_size_i);

  // per-step loop ranges and outer sizes, tile y always runs over seq tiles
  always_comb begin
    x_tiles      = '0;
    inner_tiles  = '0;
    first_dim_o  = '0;
    second_dim_o = '0;
    case (step_q)
      MATMUL: begin
        x_tiles      = proj_tiles;
        inner_tiles  = embed_tiles;
        first_dim_o  = seq_length_i;
        second_dim_o = proj_space_i;
      end
      F1: begin
        x_tiles      = ff_tiles;
        inner_tiles  = embed_tiles;
        first_dim_o  = seq_length_i;
        second_dim_o = ff_size_i;
      end
      F2: begin
        x_tiles      = embed_tiles;
        inner_tiles  = ff_tiles;
        first_dim_o  = seq_length_i;
        second_dim_o = embed_size_i;
      end
      default: ;
    endcase
  end

  assign last_beat  = beat_q == BeatW'(BeatsPerTile - 1);
  assign last_inner = inner_tile_q == inner_tiles - 1'b1;
  assign last_x     = tile_x_q == x_tiles - 1'b1;
  assign last_y     = tile_y_q == seq_tiles - 1'b1;

  always_comb begin
    step_d       = step_q;
    beat_d       = beat_q;
    tile_x_d     = tile_x_q;
    tile_y_d     = tile_y_q;
    inner_tile_d = inner_tile_q;
    if (step_q == IDLE) begin
      if (start_i) begin
        step_d = (layer_i == LINEAR) ? MATMUL : F1;
      end
    end else if (accept_i) begin
      beat_d = beat_q + 1'b1;
      if (last_beat) begin // inner tile done
        beat_d       = '0;
        inner_tile_d = inner_tile_q + 1'b1;
        if (last_inner) begin // output tile done
          inner_tile_d = '0;
          tile_x_d     = tile_x_q + 1'b1;
          if (last_x) begin
            tile_x_d = '0;
            tile_y_d = tile_y_q + 1'b1;
            if (last_y) begin // step done
              tile_y_d = '0;
              step_d   = (step_q == F1) ? F2 : IDLE;
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q       <= IDLE;
      beat_q       <= '0;
      tile_x_q     <= '0;
      tile_y_q     <= '0;
      inner_tile_q <= '0;
    end else begin
      step_q       <= step_d;
      beat_q       <= beat_d;
      tile_x_q     <= tile_x_d;
      tile_y_q     <= tile_y_d;
      inner_tile_q <= inner_tile_d;
    end
  end

  assign step_o             = step_q;
  assign beat_o             = beat_q;
  assign tile_x_o           = tile_x_q;
  assign tile_y_o           = tile_y_q;
  assign inner_tile_o       = inner_tile_q;
  assign first_inner_tile_o = inner_tile_q == '0;
  assign last_inner_tile_o  = (step_q != IDLE) && last_inner;

endmodule

//--- hw/flow_throttle.sv
/* Beat acceptance and outstanding-output tracking.
   Readies drop while FifoDepth output beats are still in flight. */

module flow_throttle #(
  parameter int unsigned FifoDepth = tile_ctrl_pkg::FifoDepth
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  tile_ctrl_pkg::step_e step_i,
  input  logic                 last_inner_tile_i,
  input  logic                 inp_valid_i,
  input  logic                 weight_valid_i,
  input  logic                 bias_valid_i,
  input  logic                 oup_valid_i,
  input  logic                 oup_ready_i,
  output logic                 inp_ready_o,
  output logic                 weight_ready_o,
  output logic                 bias_ready_o,
  output logic                 accept_o
);
  import tile_ctrl_pkg::*;

  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  logic [CntW-1:0] ongoing_d, ongoing_q;
  logic            stall, active;
  logic            push, pop;

  assign stall  = ongoing_q >= CntW'(FifoDepth);
  assign active = (step_i != IDLE) && !stall;

  assign inp_ready_o    = active && weight_valid_i;
  assign weight_ready_o = active && inp_valid_i;
  assign bias_ready_o   = active && weight_valid_i;
  assign accept_o       = active && inp_valid_i && weight_valid_i && bias_valid_i;

  assign push = accept_o && last_inner_tile_i; // beat that produces output
  assign pop  = oup_valid_i && oup_ready_i;

  always_comb begin
    ongoing_d = ongoing_q;
    if (push && !pop) begin
      ongoing_d = ongoing_q + 1'b1;
    end else if (pop && !push) begin
      ongoing_d = ongoing_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ongoing_q <= '0;
    end else begin
      ongoing_q <= ongoing_d;
    end
  end

endmodule

//--- hw/tile_ctrl_pkg.sv
/* Shared types and default sizes for the tile controller.
   Modules pick the defaults up as parameter values; the testbench uses the enums. */

package tile_ctrl_pkg;

  // controller step
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    MATMUL = 2'd1,
    F1     = 2'd2,
    F2     = 2'd3
  } step_e;

  // host layer opcode
  typedef enum logic {
    LINEAR      = 1'b0,
    FEEDFORWARD = 1'b1
  } layer_e;

  // tile edge, power of two
  localparam int unsigned TileM = 8;

  // columns per beat, divides TileM
  localparam int unsigned Lanes = 4;

  // max output beats in flight
  localparam int unsigned FifoDepth = 8;

  localparam int unsigned DimW  = 10; // matrix size width
  localparam int unsigned BiasW = 8;  // one bias lane

endpackage
